// ==== flist.f ====
+incdir+include
verilog/keypad_pkg.sv
verilog/cpu_io_pkg.sv
verilog/keypad_scanner.sv
verilog/input_unit.sv
verilog/input_port.sv
verilog/user_input_top.sv
testbench/tb_user_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_user_input \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_user_input > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a result"; exit 1; }
echo "run passed"

// ==== testbench/tb_user_input.sv ====
`timescale 1ns/1ps
`include "input_params.svh"

module tb_user_input;
    import keypad_pkg::*;
    import cpu_io_pkg::*;

    localparam int PRESS_LIMIT    = 400;  // cycles allowed for one debounced press
    localparam int PRESS_COUNT    = 60;
    localparam int TIMEOUT_CYCLES = PRESS_COUNT * PRESS_LIMIT + 16000;
    localparam int RELEASE_CYCLES = (`DEBOUNCE_SCANS + 2) * 4 * `SCAN_DIV;
    localparam int HOLD_CYCLES    = 4;

    logic                   clk;
    logic                   rst_n;
    logic [3:0]             row;
    logic [3:0]             col;
    logic [`SWITCH_CNT-1:0] switch_map;
    logic                   uart_complete;
    logic                   in_req;
    logic                   in_ack;
    logic [`ISA_WIDTH-1:0]  in_data;
    logic                   cpu_pause;
    logic                   switch_enable;
    input_state_e           input_state;

    key_code_e             held_key;       // key the model holds down
    key_event_t            seen_evt;
    logic [`ISA_WIDTH-1:0] expected_data;  // reference word for the next ack
    logic [`ISA_WIDTH-1:0] model_acc;
    int                    model_cnt;
    int                    seed = 32'h6f49;
    int                    error_count = 0;
    int                    errors_at_start = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    cycle_count = 0;
    int                    ack_rises = 0;
    logic                  ack_seen = 1'b0;

    user_input_top u_user_input_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .row           (row),
        .col           (col),
        .switch_map    (switch_map),
        .uart_complete (uart_complete),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .in_data       (in_data),
        .cpu_pause     (cpu_pause),
        .switch_enable (switch_enable),
        .input_state   (input_state)
    );

    assign seen_evt = u_user_input_top.key_evt;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // standard layout: 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
    function automatic logic [1:0] key_row(input key_code_e k);
        case (k)
            K1, K2, K3, K_PAUSE:  key_row = 2'd0;
            K4, K5, K6, K_TOGGLE: key_row = 2'd1;
            K7, K8, K9, K_C:      key_row = 2'd2;
            default:              key_row = 2'd3;
        endcase
    endfunction

    function automatic logic [1:0] key_col(input key_code_e k);
        case (k)
            K1, K4, K7, K_BACK:  key_col = 2'd0;
            K2, K5, K8, K0:      key_col = 2'd1;
            K3, K6, K9, K_ENTER: key_col = 2'd2;
            default:             key_col = 2'd3;
        endcase
    endfunction

    // a held key pulls its row low while its column is strobed
    always_comb begin
        row = 4'hF;
        if (held_key != K_NONE && col[key_col(held_key)] == 1'b0) begin
            row[key_row(held_key)] = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run is still going after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (in_ack && !ack_seen) ack_rises++;
        ack_seen = in_ack;
    end

    ack_data_match: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> in_data == expected_data)
        else begin
            error_count++;
            $display("[FAIL] %0t in_data %0d at ack, expected %0d", $time, in_data, expected_data);
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_ack) |-> in_req)
        else begin
            error_count++;
            $display("[FAIL] %0t in_ack rose without in_req", $time);
        end

    ack_holds_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        (in_ack && in_req) |=> in_ack)
        else begin
            error_count++;
            $display("[FAIL] %0t in_ack fell while in_req was high", $time);
        end

    data_stable_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        in_ack |=> (!in_ack || $stable(in_data)))
        else begin
            error_count++;
            $display("[FAIL] %0t in_data changed while in_ack was high", $time);
        end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            error_count++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic press_key(input key_code_e k);
        int waited;
        waited = 0;
        @(negedge clk);
        held_key = k;
        while (!seen_evt.valid && waited < PRESS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!seen_evt.valid) begin
            error_count++;
            $display("key %s gave no key event within %0d cycles", k.name(), PRESS_LIMIT);
        end
        held_key = K_NONE;
        repeat (RELEASE_CYCLES) @(negedge clk);  // scanner arms again after release
    endtask

    task automatic type_digit(input int d);
        press_key(key_code_e'(5'(d)));
        if (model_cnt < `MAX_DIGITS) begin
            model_acc = model_acc * 10 + d;
            model_cnt++;
        end
    endtask

    task automatic press_back();
        press_key(K_BACK);
        if (model_cnt != 0) begin
            model_acc = model_acc / 10;
            model_cnt--;
        end
    endtask

    task automatic request_word();
        int waited;
        waited = 0;
        @(negedge clk);
        in_req    = 1'b1;
        model_acc = '0;
        model_cnt = 0;
        while (input_state != KEYPAD && waited < PRESS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (input_state != KEYPAD) begin
            error_count++;
            $display("in_req did not start keypad entry within %0d cycles", PRESS_LIMIT);
        end
    endtask

    // confirm with ENTER or PAUSE and close the four-phase handshake
    task automatic finish_entry(input key_code_e k, input logic [31:0] exp);
        int waited;
        waited = 0;
        expected_data = exp;
        press_key(k);
        while (!in_ack && waited < PRESS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ack) begin
            error_count++;
            $display("no in_ack after key %s within %0d cycles", k.name(), PRESS_LIMIT);
        end
        check_eq("in_data", in_data, exp);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_eq("in_ack while in_req high", 32'(in_ack), 1);
        end
        in_req = 1'b0;
        @(negedge clk);
        check_eq("in_ack one cycle after in_req falls", 32'(in_ack), 0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    task automatic test_reset_idle();
        check_eq("in_ack after reset", 32'(in_ack), 0);
        check_eq("cpu_pause after reset", 32'(cpu_pause), 0);
        check_eq("switch_enable after reset", 32'(switch_enable), 0);
        check_eq("input_state after reset", 32'(input_state), 32'(BLOCK));
        press_key(K1);
        press_key(K2);
        check_eq("input_state without request", 32'(input_state), 32'(BLOCK));
        check_eq("ack count without request", ack_rises, 0);
        end_test("reset and idle digits");
    endtask

    task automatic test_basic_entry();
        request_word();
        type_digit(4);
        type_digit(7);
        press_back();
        type_digit(2);
        type_digit(5);
        finish_entry(K_ENTER, model_acc);  // 425
        end_test("entry with backspace");
    endtask

    task automatic test_digit_limit();
        int i;
        request_word();
        for (i = 0; i < 12; i++) type_digit((i * 7 + 3) % 10);
        finish_entry(K_ENTER, model_acc);
        request_word();
        press_back();
        press_back();
        type_digit(7);  // the digit count must still be zero here
        finish_entry(K_ENTER, model_acc);
        end_test("digit limit and empty backspace");
    endtask

    task automatic test_switch_toggle();
        logic [31:0] exp;
        logic [31:0] rand_word;
        request_word();
        type_digit(3);
        type_digit(1);
        press_key(K_TOGGLE);
        check_eq("switch_enable after toggle", 32'(switch_enable), 1);
        check_eq("input_state after toggle", 32'(input_state), 32'(SWITCH));
        press_key(K_TOGGLE);
        check_eq("switch_enable after toggle back", 32'(switch_enable), 0);
        type_digit(8);
        finish_entry(K_ENTER, model_acc);  // earlier digits survive the detour
        request_word();
        press_key(K_TOGGLE);
        rand_word  = $random(seed);
        switch_map = rand_word[`SWITCH_CNT-1:0];
        exp = '0;
        exp[`SWITCH_CNT-1:0] = switch_map;
        finish_entry(K_ENTER, exp);
        end_test("switch entry and toggle");
    endtask

    task automatic test_pause_request();
        request_word();
        type_digit(5);
        type_digit(6);
        finish_entry(K_PAUSE, model_acc);
        check_eq("cpu_pause after pause", 32'(cpu_pause), 1);
        check_eq("input_state after pause", 32'(input_state), 32'(HALT));
        press_key(K_PAUSE);
        check_eq("cpu_pause without upload done", 32'(cpu_pause), 1);
        uart_complete = 1'b1;
        press_key(K_PAUSE);
        check_eq("cpu_pause after resume", 32'(cpu_pause), 0);
        check_eq("input_state after resume", 32'(input_state), 32'(BLOCK));
        uart_complete = 1'b0;
        end_test("pause during entry");
    endtask

    task automatic test_pause_idle();
        int acks_before;
        acks_before = ack_rises;
        press_key(K_PAUSE);
        check_eq("cpu_pause from block", 32'(cpu_pause), 1);
        check_eq("input_state from block", 32'(input_state), 32'(HALT));
        check_eq("ack count after idle pause", ack_rises, acks_before);
        uart_complete = 1'b1;
        press_key(K_PAUSE);
        uart_complete = 1'b0;
        check_eq("cpu_pause after idle resume", 32'(cpu_pause), 0);
        end_test("pause without request");
    endtask

    initial begin
        rst_n         = 1'b0;
        held_key      = K_NONE;
        switch_map    = '0;
        uart_complete = 1'b0;
        in_req        = 1'b0;
        expected_data = '0;
        model_acc     = '0;
        model_cnt     = 0;
        repeat (10) @(negedge clk);
        check_eq("col during reset", 32'(col), 32'(4'b1110));
        rst_n = 1'b1;
        repeat (RELEASE_CYCLES) @(negedge clk);
        test_reset_idle();
        test_basic_entry();
        test_digit_limit();
        test_switch_toggle();
        test_pause_request();
        test_pause_idle();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/user_input_top.sv ====
`timescale 1ns/1ps
`include "input_params.svh"

module user_input_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [3:0]               row,            // keypad rows, active low
    output logic [3:0]               col,            // keypad columns, active low
    input  logic [`SWITCH_CNT-1:0]   switch_map,
    input  logic                     uart_complete,
    input  logic                     in_req,
    output logic                     in_ack,
    output logic [`ISA_WIDTH-1:0]    in_data,
    output logic                     cpu_pause,
    output logic                     switch_enable,
    output cpu_io_pkg::input_state_e input_state
);
    import keypad_pkg::*;
    import cpu_io_pkg::*;

    key_event_t  key_evt;
    input_word_t word;
    logic        done;
    logic        busy;

    keypad_scanner u_scanner (
        .clk     (clk),
        .rst_n   (rst_n),
        .row     (row),
        .col     (col),
        .key_evt (key_evt)
    );

    input_unit u_input (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_evt       (key_evt),
        .switch_map    (switch_map),
        .uart_complete (uart_complete),
        .busy          (busy),
        .word          (word),
        .done          (done),
        .cpu_pause     (cpu_pause),
        .switch_enable (switch_enable),
        .input_state   (input_state)
    );

    input_port u_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .word    (word),
        .done    (done),
        .busy    (busy),
        .in_ack  (in_ack),
        .in_data (in_data)
    );

endmodule

// ==== verilog/input_port.sv ====
`timescale 1ns/1ps
`include "input_params.svh"

module input_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_req,   // held high by data memory until ack
    input  cpu_io_pkg::input_word_t word,
    input  logic                    done,
    output logic                    busy,
    output logic                    in_ack,
    output logic [`ISA_WIDTH-1:0]   in_data
);
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        WAIT_WORD = 2'b01,  // request open, user still typing
        ACKED     = 2'b10   // word delivered, waiting for req to drop
    } port_state_e;

    port_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (in_req) begin
                        state <= WAIT_WORD;  // ack is always low here
                    end
                end
                WAIT_WORD: begin
                    if (done) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    if (!in_req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // in_data only changes while ack is low
    always_ff @(posedge clk) begin
        if (state == WAIT_WORD && done) begin
            in_data <= word.data;
        end
    end

    // drops together with done so the input unit stays in BLOCK
    assign busy   = (state == WAIT_WORD) && !done;
    assign in_ack = (state == ACKED);

endmodule

// ==== verilog/input_unit.sv ====
`timescale 1ns/1ps
`include "input_params.svh"

module input_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  keypad_pkg::key_event_t   key_evt,
    input  logic [`SWITCH_CNT-1:0]   switch_map,
    input  logic                     uart_complete,  // upload link finished
    input  logic                     busy,           // data memory waits for a word
    output cpu_io_pkg::input_word_t  word,
    output logic                     done,
    output logic                     cpu_pause,
    output logic                     switch_enable,
    output cpu_io_pkg::input_state_e input_state
);
    import keypad_pkg::*;
    import cpu_io_pkg::*;

    localparam int CNT_W = $clog2(`MAX_DIGITS + 1);
    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(`MAX_DIGITS);

    logic [`ISA_WIDTH-1:0] acc;        // decimal value typed so far
    logic [CNT_W-1:0]      digit_cnt;
    logic [`ISA_WIDTH-1:0] digit_val;
    logic [`ISA_WIDTH-1:0] switch_val;
    logic                  key_digit;
    logic                  key_back;
    logic                  key_enter;
    logic                  key_pause;
    logic                  key_toggle;

    assign key_digit  = key_evt.valid && (key_evt.code <= K9);
    assign key_back   = key_evt.valid && (key_evt.code == K_BACK);
    assign key_enter  = key_evt.valid && (key_evt.code == K_ENTER);
    assign key_pause  = key_evt.valid && (key_evt.code == K_PAUSE);
    assign key_toggle = key_evt.valid && (key_evt.code == K_TOGGLE);
    // C, D and K_NONE fall through every branch below

    assign digit_val  = {{(`ISA_WIDTH - 5){1'b0}}, key_evt.code};
    assign switch_val = {{(`ISA_WIDTH - `SWITCH_CNT){1'b0}}, switch_map};

    // switch_enable stays set into BLOCK so the port captures the right source
    assign word = '{data: switch_enable ? switch_val : acc, from_switch: switch_enable};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_state   <= BLOCK;
            acc           <= '0;
            digit_cnt     <= '0;
            done          <= 1'b0;
            cpu_pause     <= 1'b0;
            switch_enable <= 1'b0;
        end else begin
            done <= 1'b0;  // single cycle pulse
            case (input_state)
                BLOCK: begin
                    if (key_pause) begin
                        input_state <= HALT;  // pause without a request
                        cpu_pause   <= 1'b1;
                    end else if (busy) begin
                        input_state   <= KEYPAD;  // fresh entry for each request
                        switch_enable <= 1'b0;
                        acc           <= '0;
                        digit_cnt     <= '0;
                    end
                end
                KEYPAD: begin
                    if (key_toggle) begin
                        input_state   <= SWITCH;
                        switch_enable <= 1'b1;
                    end else if (key_enter) begin
                        input_state <= BLOCK;
                        done        <= 1'b1;
                    end else if (key_pause) begin
                        input_state <= HALT;  // complete the request with the current value
                        done        <= 1'b1;
                        cpu_pause   <= 1'b1;
                    end else if (key_back) begin
                        if (digit_cnt != '0) begin
                            acc       <= acc / 10;
                            digit_cnt <= digit_cnt - 1'b1;
                        end
                    end else if (key_digit && digit_cnt < MAX_CNT) begin
                        acc       <= acc * 10 + digit_val;
                        digit_cnt <= digit_cnt + 1'b1;
                    end
                end
                SWITCH: begin
                    if (key_toggle) begin
                        input_state   <= KEYPAD;  // typed digits are kept
                        switch_enable <= 1'b0;
                    end else if (key_enter) begin
                        input_state <= BLOCK;
                        done        <= 1'b1;
                    end else if (key_pause) begin
                        input_state <= HALT;
                        done        <= 1'b1;
                        cpu_pause   <= 1'b1;
                    end
                end
                HALT: begin
                    // resume only once the upload is finished
                    if (key_pause && uart_complete) begin
                        input_state <= BLOCK;
                        cpu_pause   <= 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== verilog/keypad_scanner.sv ====
`timescale 1ns/1ps
`include "input_params.svh"

module keypad_scanner (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             row,
    output logic [3:0]             col,
    output keypad_pkg::key_event_t key_evt
);
    import keypad_pkg::*;

    localparam int DIV_W = (`SCAN_DIV > 1) ? $clog2(`SCAN_DIV) : 1;
    localparam int DB_W  = $clog2(`DEBOUNCE_SCANS + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);
    localparam logic [DB_W-1:0]  DB_DONE  = DB_W'(`DEBOUNCE_SCANS);
    localparam logic [7:0]       NO_KEY   = 8'hFF;

    logic [DIV_W-1:0] div_cnt;
    logic             step;          // last cycle of a column slot
    logic [1:0]       col_idx;
    logic             sweep_end;
    logic [3:0]       row_meta;
    logic [3:0]       row_sync;
    logic [7:0]       sweep_coord;   // pressed key seen so far in this sweep
    logic [7:0]       sample_coord;  // sweep result including the current column
    logic [7:0]       last_coord;    // result of the previous sweep
    logic [DB_W-1:0]  stable_cnt;
    logic [DB_W-1:0]  stable_nxt;
    logic             settled;
    logic             armed;         // a release was seen since the last event
    logic             fire;
    logic             evt_valid;
    key_code_e        evt_code;
    logic [7:0]       evt_coord;

    // layout follows the board wiring, row in the upper nibble
    function automatic key_code_e coord_to_code(input logic [7:0] coord);
        case (coord)
            8'b0111_1101: coord_to_code = K0;
            8'b1110_1110: coord_to_code = K1;
            8'b1110_1101: coord_to_code = K2;
            8'b1110_1011: coord_to_code = K3;
            8'b1101_1110: coord_to_code = K4;
            8'b1101_1101: coord_to_code = K5;
            8'b1101_1011: coord_to_code = K6;
            8'b1011_1110: coord_to_code = K7;
            8'b1011_1101: coord_to_code = K8;
            8'b1011_1011: coord_to_code = K9;
            8'b0111_1110: coord_to_code = K_BACK;
            8'b0111_1011: coord_to_code = K_ENTER;
            8'b1110_0111: coord_to_code = K_PAUSE;
            8'b1101_0111: coord_to_code = K_TOGGLE;
            8'b1011_0111: coord_to_code = K_C;
            8'b0111_0111: coord_to_code = K_D;
            default:      coord_to_code = K_NONE;  // several keys or nothing
        endcase
    endfunction

    assign step         = (div_cnt == DIV_LAST);
    assign sweep_end    = step && (col_idx == 2'd3);
    assign sample_coord = (row_sync != 4'hF) ? {row_sync, col} : sweep_coord;

    // count sweeps with an unchanged reading, saturating once settled
    always_comb begin
        if (sample_coord != last_coord) begin
            stable_nxt = DB_W'(1);
        end else if (stable_cnt == DB_DONE) begin
            stable_nxt = stable_cnt;
        end else begin
            stable_nxt = stable_cnt + 1'b1;
        end
    end

    assign settled = sweep_end && (stable_nxt == DB_DONE);
    assign fire    = settled && armed && (sample_coord != NO_KEY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_meta <= 4'hF;
            row_sync <= 4'hF;
        end else begin
            row_meta <= row;  // rows come straight from the pads
            row_sync <= row_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt     <= '0;
            col_idx     <= 2'd0;
            col         <= 4'b1110;
            sweep_coord <= NO_KEY;
            last_coord  <= NO_KEY;
            stable_cnt  <= '0;
            armed       <= 1'b0;  // a key held through reset needs a release first
            evt_valid   <= 1'b0;
        end else begin
            evt_valid <= fire;
            div_cnt   <= step ? '0 : div_cnt + 1'b1;
            if (step) begin
                col     <= {col[2:0], col[3]};  // walk the low bit to the next column
                col_idx <= col_idx + 1'b1;
                if (sweep_end) begin
                    sweep_coord <= NO_KEY;
                    last_coord  <= sample_coord;
                    stable_cnt  <= stable_nxt;
                    if (fire) begin
                        armed <= 1'b0;
                    end else if (settled && sample_coord == NO_KEY) begin
                        armed <= 1'b1;
                    end
                end else begin
                    sweep_coord <= sample_coord;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            evt_code  <= coord_to_code(sample_coord);
            evt_coord <= sample_coord;
        end
    end

    assign key_evt = '{valid: evt_valid, code: evt_code, coord: evt_coord};

endmodule

// ==== verilog/cpu_io_pkg.sv ====
`include "input_params.svh"

package cpu_io_pkg;

    // entry modes of the input unit
    typedef enum logic [1:0] {
        BLOCK  = 2'b00,  // no request pending
        SWITCH = 2'b01,  // word comes from the toggle switches
        KEYPAD = 2'b10,  // word is typed as decimal digits
        HALT   = 2'b11   // cpu paused for upload
    } input_state_e;

    // word offered to data memory
    typedef struct packed {
        logic [`ISA_WIDTH-1:0] data;
        logic                  from_switch;  // data is the zero extended switch map
    } input_word_t;

endpackage

// ==== verilog/keypad_pkg.sv ====
package keypad_pkg;

    // one code per key of the 4x4 matrix
    typedef enum logic [4:0] {
        K0       = 5'd0,
        K1       = 5'd1,
        K2       = 5'd2,
        K3       = 5'd3,
        K4       = 5'd4,
        K5       = 5'd5,
        K6       = 5'd6,
        K7       = 5'd7,
        K8       = 5'd8,
        K9       = 5'd9,
        K_BACK   = 5'd10,  // "*" deletes the last digit
        K_ENTER  = 5'd11,  // "#" confirms the number
        K_PAUSE  = 5'd12,  // "A" pauses or resumes the cpu
        K_TOGGLE = 5'd13,  // "B" switches between keypad and switches
        K_C      = 5'd14,
        K_D      = 5'd15,
        K_NONE   = 5'd16
    } key_code_e;

    // digit keys share their value with their code
    // coord is {row, col}, both one-hot-low
    typedef struct packed {
        logic      valid;  // single cycle pulse per press
        key_code_e code;
        logic [7:0] coord;
    } key_event_t;

endpackage

// ==== include/input_params.svh ====
`ifndef INPUT_PARAMS_SVH
`define INPUT_PARAMS_SVH

// data word returned to data memory
`define ISA_WIDTH 32

// toggle switches on the board, must not exceed ISA_WIDTH
`define SWITCH_CNT 16

// nine decimal digits always fit in a 32-bit word
`define MAX_DIGITS 9

// clock cycles per keypad column step
// keep at 3 or more so the row synchronizer settles before sampling
// a board build with a fast clock sets a much larger value here
`define SCAN_DIV 4

// full sweeps with an identical reading before a press or release counts
`define DEBOUNCE_SCANS 2

`endif
